// ==== verilog/spu_isa_pkg.sv ====
`default_nettype none

package spu_isa_pkg;

	localparam int instr_width = 32;
	localparam int reg_addr_width = 7;
	localparam int imm_width = 18;
	localparam int opcode_width = 11;

	// opcode bits left-justified in 11 bits
	typedef enum logic [0:opcode_width-1] {
		e_none  = 11'b00000000000,
		e_mpya  = 11'b11000000000,	// rrr
		e_fma   = 11'b11100000000,
		e_fms   = 11'b11110000000,
		e_ila   = 11'b01000010000,	// ri18
		e_cflts = 11'b01110110000,	// ri8
		e_ilh   = 11'b01000001100,	// ri16
		e_ilhu  = 11'b01000001000,
		e_iohl  = 11'b01100000100,
		e_mpyi  = 11'b01110100000,	// ri10
		e_ai    = 11'b00011100000,
		e_andi  = 11'b00010100000,
		e_ori   = 11'b00000100000,
		e_ceqi  = 11'b01111100000,
		e_mpy   = 11'b01111000100,	// rr
		e_fa    = 11'b01011000100,
		e_fm    = 11'b01011000110,
		e_shl   = 11'b00001011011,
		e_cntb  = 11'b01010110100,
		e_a     = 11'b00011000000,
		e_and   = 11'b00011000001,
		e_nop   = 11'b01000000001,
		e_shli  = 11'b00001111011,	// ri7
		e_roti  = 11'b00001111000
	} even_op_e;

	typedef enum logic [0:opcode_width-1] {
		o_none    = 11'b00000000000,
		o_lqd     = 11'b00110100000,	// ri10
		o_lqa     = 11'b00110000100,	// ri16
		o_stqa    = 11'b00100000100,
		o_br      = 11'b00110010000,
		o_brsl    = 11'b00110011000,
		o_brz     = 11'b00100000000,
		o_shlqbi  = 11'b00111011011,	// rr
		o_lqx     = 11'b00111000100,
		o_stqx    = 11'b00101000100,
		o_bi      = 11'b00110101000,
		o_lnop    = 11'b00000000001,
		o_shlqbii = 11'b00111111011,	// ri7
		o_rotqbyi = 11'b00111111100,
		o_illegal = 11'b11111111111
	} odd_op_e;

	typedef enum logic [2:0] {
		fmt_rr, fmt_rrr, fmt_ri7, fmt_ri8, fmt_ri10, fmt_ri16, fmt_ri18
	} format_e;

	typedef enum logic [1:0] {unit_fp, unit_fx2, unit_byte, unit_fx1} even_unit_e;
	typedef enum logic [1:0] {unit_perm, unit_ls, unit_br} odd_unit_e;

	// sign-extended immediate of a given format
	function automatic logic [0:imm_width-1] sext_imm(logic [0:instr_width-1] instr,
			format_e fmt);
		case (fmt)
			fmt_ri7:  return {{11{instr[11]}}, instr[11:17]};
			fmt_ri8:  return {{10{instr[10]}}, instr[10:17]};
			fmt_ri10: return {{8{instr[8]}}, instr[8:17]};
			fmt_ri16: return {{2{instr[9]}}, instr[9:24]};
			fmt_ri18: return instr[7:24];
			default:  return '0;	// register forms carry no immediate
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== verilog/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

	localparam int pc_width = 8;

	// pipe a fetched word is routed to
	typedef enum logic [1:0] {
		cls_stop,
		cls_even,
		cls_odd
	} pipe_class_e;

	typedef enum logic [1:0] {
		st_idle,
		st_second_half,	// slot1 of a split pair goes out now
		st_done	// stop seen, wait for reset
	} split_state_e;

endpackage

`default_nettype wire

// ==== verilog/even_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module even_decoder (
	input  logic [0:spu_isa_pkg::instr_width-1] instr,
	output logic known,
	output spu_isa_pkg::even_op_e op,
	output spu_isa_pkg::format_e format,
	output spu_isa_pkg::even_unit_e unit,
	output logic [0:spu_isa_pkg::reg_addr_width-1] rt,
	output logic [0:spu_isa_pkg::reg_addr_width-1] ra,
	output logic [0:spu_isa_pkg::reg_addr_width-1] rb,
	output logic [0:spu_isa_pkg::reg_addr_width-1] rc,
	output logic [0:spu_isa_pkg::imm_width-1] imm,
	output logic reg_write
);
	import spu_isa_pkg::*;

	logic [0:opcode_width-1] rrr_key, ri18_key, ri8_key, ri16_key, ri10_key;

	// opcode prefixes padded out to the full opcode width
	assign rrr_key = {instr[0:3], 7'b0};
	assign ri18_key = {instr[0:6], 4'b0};
	assign ri8_key = {instr[0:9], 1'b0};
	assign ri16_key = {instr[0:8], 2'b0};
	assign ri10_key = {instr[0:7], 3'b0};

	always_comb begin
		known = 1'b1;
		if (rrr_key inside {e_mpya, e_fma, e_fms}) begin	// short prefixes first
			op = even_op_e'(rrr_key);
			format = fmt_rrr;
		end else if (ri18_key == e_ila) begin
			op = e_ila;
			format = fmt_ri18;
		end else if (ri8_key == e_cflts) begin
			op = e_cflts;
			format = fmt_ri8;
		end else if (ri16_key inside {e_ilh, e_ilhu, e_iohl}) begin
			op = even_op_e'(ri16_key);
			format = fmt_ri16;
		end else if (ri10_key inside {e_mpyi, e_ai, e_andi, e_ori, e_ceqi}) begin
			op = even_op_e'(ri10_key);
			format = fmt_ri10;
		end else if (instr[0:10] inside {e_mpy, e_fa, e_fm, e_shl, e_cntb, e_a, e_and,
				e_nop}) begin
			op = even_op_e'(instr[0:10]);
			format = fmt_rr;
		end else if (instr[0:10] inside {e_shli, e_roti}) begin
			op = even_op_e'(instr[0:10]);
			format = fmt_ri7;
		end else begin
			known = 1'b0;	// left to the odd pipe
			op = e_none;
			format = fmt_rr;
		end
	end

	always_comb begin
		case (op)
			e_none, e_mpya, e_fma, e_fms, e_cflts, e_mpyi, e_mpy, e_fa, e_fm, e_nop:
				unit = unit_fp;
			e_shl, e_shli, e_roti:
				unit = unit_fx2;
			e_cntb:
				unit = unit_byte;
			default:
				unit = unit_fx1;	// simple fixed point
		endcase
	end

	assign reg_write = known && (op != e_nop);
	assign rt = (format == fmt_rrr) ? instr[4:10] : instr[25:31];	// rrr moves rt up front
	assign ra = instr[18:24];
	assign rb = instr[11:17];
	assign rc = instr[25:31];
	assign imm = sext_imm(instr, format);

endmodule

`default_nettype wire

// ==== verilog/odd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module odd_decoder (
	input  logic [0:spu_isa_pkg::instr_width-1] instr,
	output spu_isa_pkg::odd_op_e op,
	output spu_isa_pkg::format_e format,
	output spu_isa_pkg::odd_unit_e unit,
	output logic [0:spu_isa_pkg::reg_addr_width-1] rt,
	output logic [0:spu_isa_pkg::reg_addr_width-1] ra,
	output logic [0:spu_isa_pkg::reg_addr_width-1] rb,
	output logic [0:spu_isa_pkg::imm_width-1] imm,
	output logic reg_write
);
	import spu_isa_pkg::*;

	logic [0:opcode_width-1] ri10_key, ri16_key;

	assign ri10_key = {instr[0:7], 3'b0};
	assign ri16_key = {instr[0:8], 2'b0};

	always_comb begin
		if (ri10_key == o_lqd) begin
			op = o_lqd;
			format = fmt_ri10;
		end else if (ri16_key inside {o_lqa, o_stqa, o_br, o_brsl, o_brz}) begin
			op = odd_op_e'(ri16_key);
			format = fmt_ri16;
		end else if (instr[0:10] inside {o_shlqbi, o_lqx, o_stqx, o_bi, o_lnop}) begin
			op = odd_op_e'(instr[0:10]);
			format = fmt_rr;
		end else if (instr[0:10] inside {o_shlqbii, o_rotqbyi}) begin
			op = odd_op_e'(instr[0:10]);
			format = fmt_ri7;
		end else begin
			op = (instr == '0) ? o_none : o_illegal;	// stop word is not illegal
			format = fmt_rr;
		end
	end

	always_comb begin
		case (op)
			o_lqd, o_lqa, o_stqa, o_lqx, o_stqx: unit = unit_ls;
			o_br, o_brsl, o_brz, o_bi:           unit = unit_br;
			default:                             unit = unit_perm;
		endcase
	end

	// stores, plain branches and lnop leave rt alone
	assign reg_write = !(op inside {o_none, o_illegal, o_lnop, o_stqa, o_stqx, o_br,
		o_brz, o_bi});
	assign rt = instr[25:31];
	assign ra = instr[18:24];
	assign rb = instr[11:17];
	assign imm = sext_imm(instr, format);

endmodule

`default_nettype wire

// ==== verilog/pair_dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_dispatcher (
	input  logic clk,
	input  logic reset,
	input  logic slot0_even_known, slot1_even_known,
	input  spu_isa_pkg::even_op_e slot0_even_op, slot1_even_op,
	input  spu_isa_pkg::format_e slot0_even_format, slot1_even_format,
	input  spu_isa_pkg::even_unit_e slot0_even_unit, slot1_even_unit,
	input  logic [0:spu_isa_pkg::reg_addr_width-1] slot0_even_rt, slot1_even_rt,
	input  logic [0:spu_isa_pkg::reg_addr_width-1] slot0_even_ra, slot1_even_ra,
	input  logic [0:spu_isa_pkg::reg_addr_width-1] slot0_even_rb, slot1_even_rb,
	input  logic [0:spu_isa_pkg::reg_addr_width-1] slot0_even_rc, slot1_even_rc,
	input  logic [0:spu_isa_pkg::imm_width-1] slot0_even_imm, slot1_even_imm,
	input  logic slot0_even_reg_write, slot1_even_reg_write,
	input  spu_isa_pkg::odd_op_e slot0_odd_op, slot1_odd_op,
	input  spu_isa_pkg::format_e slot0_odd_format, slot1_odd_format,
	input  spu_isa_pkg::odd_unit_e slot0_odd_unit, slot1_odd_unit,
	input  logic [0:spu_isa_pkg::reg_addr_width-1] slot0_odd_rt, slot1_odd_rt,
	input  logic [0:spu_isa_pkg::reg_addr_width-1] slot0_odd_ra, slot1_odd_ra,
	input  logic [0:spu_isa_pkg::reg_addr_width-1] slot0_odd_rb, slot1_odd_rb,
	input  logic [0:spu_isa_pkg::imm_width-1] slot0_odd_imm, slot1_odd_imm,
	input  logic slot0_odd_reg_write, slot1_odd_reg_write,
	input  logic slot0_zero, slot1_zero,
	output logic stall, finished, first_odd,
	output logic even_valid,
	output spu_isa_pkg::even_op_e even_op,
	output spu_isa_pkg::format_e even_format,
	output spu_isa_pkg::even_unit_e even_unit,
	output logic [0:spu_isa_pkg::reg_addr_width-1] even_rt, even_ra, even_rb, even_rc,
	output logic [0:spu_isa_pkg::imm_width-1] even_imm,
	output logic even_reg_write,
	output logic odd_valid,
	output spu_isa_pkg::odd_op_e odd_op,
	output spu_isa_pkg::format_e odd_format,
	output spu_isa_pkg::odd_unit_e odd_unit,
	output logic [0:spu_isa_pkg::reg_addr_width-1] odd_rt, odd_ra, odd_rb,
	output logic [0:spu_isa_pkg::imm_width-1] odd_imm,
	output logic odd_reg_write
);
	import spu_isa_pkg::*;
	import decode_pkg::*;

	pipe_class_e class0, class1;
	split_state_e state, nxt_state;
	logic conflict, split;
	logic nxt_even_valid, nxt_odd_valid, nxt_first_odd;
	logic even_sel, odd_sel;	// 1 picks slot1 fields

	assign class0 = slot0_zero ? cls_stop : (slot0_even_known ? cls_even : cls_odd);
	assign class1 = slot1_zero ? cls_stop : (slot1_even_known ? cls_even : cls_odd);

	// same target on both pipes, only looked at for mixed pairs
	always_comb begin
		if (class0 == cls_even)
			conflict = slot0_even_reg_write && slot1_odd_reg_write &&
				(slot0_even_rt == slot1_odd_rt);
		else
			conflict = slot0_odd_reg_write && slot1_even_reg_write &&
				(slot0_odd_rt == slot1_even_rt);
	end

	assign split = (class0 != cls_stop) && (class1 != cls_stop) &&
		((class0 == class1) || conflict);

	always_comb begin
		nxt_state = state;
		nxt_even_valid = 1'b0;
		nxt_odd_valid = 1'b0;
		nxt_first_odd = 1'b0;
		even_sel = 1'b0;
		odd_sel = 1'b0;
		stall = 1'b0;
		case (state)
			st_idle: begin
				if (class0 == cls_stop) begin
					nxt_state = st_done;	// nothing issues
				end else if (split || class1 == cls_stop) begin
					nxt_even_valid = (class0 == cls_even);	// instr0 alone
					nxt_odd_valid = (class0 == cls_odd);
					stall = split;	// fetch holds for the second half
					nxt_state = split ? st_second_half : st_done;
				end else begin
					nxt_even_valid = 1'b1;
					nxt_odd_valid = 1'b1;
					even_sel = (class0 == cls_odd);
					odd_sel = (class0 == cls_even);
					nxt_first_odd = (class0 == cls_odd);
				end
			end
			st_second_half: begin
				nxt_even_valid = (class1 == cls_even);
				nxt_odd_valid = (class1 == cls_odd);
				even_sel = 1'b1;
				odd_sel = 1'b1;
				nxt_state = st_idle;
			end
			default: stall = 1'b1;	// finished
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			first_odd <= 1'b0;
		end else begin
			state <= nxt_state;
			first_odd <= nxt_first_odd;
		end
	end

	assign finished = (state == st_done);

	always_ff @(posedge clk) begin
		if (reset || !nxt_even_valid) begin	// idle pipe carries a zero bundle
			even_valid <= 1'b0;
			even_op <= e_none;
			even_format <= fmt_rr;
			even_unit <= unit_fp;
			even_rt <= '0;
			even_ra <= '0;
			even_rb <= '0;
			even_rc <= '0;
			even_imm <= '0;
			even_reg_write <= 1'b0;
		end else begin
			even_valid <= 1'b1;
			even_op <= even_sel ? slot1_even_op : slot0_even_op;
			even_format <= even_sel ? slot1_even_format : slot0_even_format;
			even_unit <= even_sel ? slot1_even_unit : slot0_even_unit;
			even_rt <= even_sel ? slot1_even_rt : slot0_even_rt;
			even_ra <= even_sel ? slot1_even_ra : slot0_even_ra;
			even_rb <= even_sel ? slot1_even_rb : slot0_even_rb;
			even_rc <= even_sel ? slot1_even_rc : slot0_even_rc;
			even_imm <= even_sel ? slot1_even_imm : slot0_even_imm;
			even_reg_write <= even_sel ? slot1_even_reg_write : slot0_even_reg_write;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || !nxt_odd_valid) begin
			odd_valid <= 1'b0;
			odd_op <= o_none;
			odd_format <= fmt_rr;
			odd_unit <= unit_perm;
			odd_rt <= '0;
			odd_ra <= '0;
			odd_rb <= '0;
			odd_imm <= '0;
			odd_reg_write <= 1'b0;
		end else begin
			odd_valid <= 1'b1;
			odd_op <= odd_sel ? slot1_odd_op : slot0_odd_op;
			odd_format <= odd_sel ? slot1_odd_format : slot0_odd_format;
			odd_unit <= odd_sel ? slot1_odd_unit : slot0_odd_unit;
			odd_rt <= odd_sel ? slot1_odd_rt : slot0_odd_rt;
			odd_ra <= odd_sel ? slot1_odd_ra : slot0_odd_ra;
			odd_rb <= odd_sel ? slot1_odd_rb : slot0_odd_rb;
			odd_imm <= odd_sel ? slot1_odd_imm : slot0_odd_imm;
			odd_reg_write <= odd_sel ? slot1_odd_reg_write : slot0_odd_reg_write;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic clk,
	input  logic reset,
	input  logic [0:spu_isa_pkg::instr_width-1] instr0,	// first in program order
	input  logic [0:spu_isa_pkg::instr_width-1] instr1,
	input  logic [decode_pkg::pc_width-1:0] pc,
	output logic stall, finished, first_odd,
	output logic even_valid,
	output spu_isa_pkg::even_op_e even_op,
	output spu_isa_pkg::format_e even_format,
	output spu_isa_pkg::even_unit_e even_unit,
	output logic [0:spu_isa_pkg::reg_addr_width-1] even_rt, even_ra, even_rb, even_rc,
	output logic [0:spu_isa_pkg::imm_width-1] even_imm,
	output logic even_reg_write,
	output logic odd_valid,
	output spu_isa_pkg::odd_op_e odd_op,
	output spu_isa_pkg::format_e odd_format,
	output spu_isa_pkg::odd_unit_e odd_unit,
	output logic [0:spu_isa_pkg::reg_addr_width-1] odd_rt, odd_ra, odd_rb,
	output logic [0:spu_isa_pkg::imm_width-1] odd_imm,
	output logic odd_reg_write
);
	import spu_isa_pkg::*;

	logic slot0_even_known, slot1_even_known, slot0_zero, slot1_zero;
	even_op_e slot0_even_op, slot1_even_op;
	odd_op_e slot0_odd_op, slot1_odd_op;
	format_e slot0_even_format, slot1_even_format, slot0_odd_format, slot1_odd_format;
	even_unit_e slot0_even_unit, slot1_even_unit;
	odd_unit_e slot0_odd_unit, slot1_odd_unit;
	logic [0:reg_addr_width-1] slot0_even_rt, slot0_even_ra, slot0_even_rb, slot0_even_rc;
	logic [0:reg_addr_width-1] slot1_even_rt, slot1_even_ra, slot1_even_rb, slot1_even_rc;
	logic [0:reg_addr_width-1] slot0_odd_rt, slot0_odd_ra, slot0_odd_rb;
	logic [0:reg_addr_width-1] slot1_odd_rt, slot1_odd_ra, slot1_odd_rb;
	logic [0:imm_width-1] slot0_even_imm, slot1_even_imm, slot0_odd_imm, slot1_odd_imm;
	logic slot0_even_reg_write, slot1_even_reg_write;
	logic slot0_odd_reg_write, slot1_odd_reg_write;

	assign slot0_zero = (instr0 == '0);	// stop word
	assign slot1_zero = (instr1 == '0);

	even_decoder u_even0 (
		.instr(instr0), .known(slot0_even_known), .op(slot0_even_op),
		.format(slot0_even_format), .unit(slot0_even_unit), .rt(slot0_even_rt),
		.ra(slot0_even_ra), .rb(slot0_even_rb), .rc(slot0_even_rc),
		.imm(slot0_even_imm), .reg_write(slot0_even_reg_write)
	);

	even_decoder u_even1 (
		.instr(instr1), .known(slot1_even_known), .op(slot1_even_op),
		.format(slot1_even_format), .unit(slot1_even_unit), .rt(slot1_even_rt),
		.ra(slot1_even_ra), .rb(slot1_even_rb), .rc(slot1_even_rc),
		.imm(slot1_even_imm), .reg_write(slot1_even_reg_write)
	);

	odd_decoder u_odd0 (
		.instr(instr0), .op(slot0_odd_op), .format(slot0_odd_format),
		.unit(slot0_odd_unit), .rt(slot0_odd_rt), .ra(slot0_odd_ra), .rb(slot0_odd_rb),
		.imm(slot0_odd_imm), .reg_write(slot0_odd_reg_write)
	);

	odd_decoder u_odd1 (
		.instr(instr1), .op(slot1_odd_op), .format(slot1_odd_format),
		.unit(slot1_odd_unit), .rt(slot1_odd_rt), .ra(slot1_odd_ra), .rb(slot1_odd_rb),
		.imm(slot1_odd_imm), .reg_write(slot1_odd_reg_write)
	);

	pair_dispatcher u_dispatch (.*);	// port names match the slot wires

endmodule

`default_nettype wire

// ==== tests/decode_stage_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage_chk (
	input logic clk,
	input logic reset,
	input logic finished,
	input logic first_odd,
	input logic even_valid,
	input logic odd_valid,
	input logic even_reg_write,
	input logic odd_reg_write,
	input logic [0:6] even_rt,
	input logic [0:6] odd_rt
);

	// outputs were cleared by the last reset edge
	after_reset_idle: assert property (@(posedge clk)
		$fell(reset) |-> !even_valid && !odd_valid && !finished && !first_odd)
		else $error("output active right after reset");

	// only reset leaves the finished state
	finished_sticky: assert property (@(posedge clk) $fell(finished) |-> $past(reset))
		else $error("finished dropped without reset");

	dual_issue_targets: assert property (@(posedge clk) disable iff (reset)
		(even_valid && odd_valid && even_reg_write && odd_reg_write) |->
			(even_rt != odd_rt))
		else $error("dual issue writes one target twice");

endmodule

bind decode_stage decode_stage_chk u_chk (.*);

`default_nettype wire

// ==== tests/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;
	import spu_isa_pkg::*;

	typedef struct packed {
		logic valid;
		logic [0:10] op;
		logic [2:0] fmt;
		logic [1:0] unit;
		logic [0:6] rt, ra, rb, rc;
		logic [0:17] imm;
		logic rw;
	} bundle_t;

	typedef struct packed {
		bundle_t ev;
		bundle_t od;
		logic first_odd;
	} issue_t;

	logic clk, reset;
	logic [0:31] instr0, instr1;
	logic [7:0] pc;
	logic stall, finished, first_odd;
	logic even_valid, even_reg_write, odd_valid, odd_reg_write;
	even_op_e even_op;
	odd_op_e odd_op;
	format_e even_format, odd_format;
	even_unit_e even_unit;
	odd_unit_e odd_unit;
	logic [0:6] even_rt, even_ra, even_rb, even_rc, odd_rt, odd_ra, odd_rb;
	logic [0:17] even_imm, odd_imm;

	integer seed;
	issue_t exp_q[$];
	logic [0:10] t_opc[64];	// left-justified encoding prefix
	logic [0:10] t_op[64];	// op the DUT should report
	format_e t_fmt[64];
	logic t_odd[64];
	logic [1:0] t_unit[64];
	logic t_rw[64];
	int n_tab;

	decode_stage u_decode_stage (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else
			report_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
	endtask

	task automatic add_op(input logic [0:10] opc, input logic [0:10] op, input format_e fmt,
			input logic odd, input logic [1:0] unit, input logic rw);
		t_opc[n_tab] = opc;
		t_op[n_tab] = op;
		t_fmt[n_tab] = fmt;
		t_odd[n_tab] = odd;
		t_unit[n_tab] = unit;
		t_rw[n_tab] = rw;
		n_tab++;
	endtask

	task automatic fill_table();
		n_tab = 0;
		add_op(e_mpya, e_mpya, fmt_rrr, 0, unit_fp, 1);
		add_op(e_fma, e_fma, fmt_rrr, 0, unit_fp, 1);
		add_op(e_fms, e_fms, fmt_rrr, 0, unit_fp, 1);
		add_op(e_ila, e_ila, fmt_ri18, 0, unit_fx1, 1);
		add_op(e_cflts, e_cflts, fmt_ri8, 0, unit_fp, 1);
		add_op(e_ilh, e_ilh, fmt_ri16, 0, unit_fx1, 1);
		add_op(e_ilhu, e_ilhu, fmt_ri16, 0, unit_fx1, 1);
		add_op(e_iohl, e_iohl, fmt_ri16, 0, unit_fx1, 1);
		add_op(e_mpyi, e_mpyi, fmt_ri10, 0, unit_fp, 1);
		add_op(e_ai, e_ai, fmt_ri10, 0, unit_fx1, 1);
		add_op(e_andi, e_andi, fmt_ri10, 0, unit_fx1, 1);
		add_op(e_ori, e_ori, fmt_ri10, 0, unit_fx1, 1);
		add_op(e_ceqi, e_ceqi, fmt_ri10, 0, unit_fx1, 1);
		add_op(e_mpy, e_mpy, fmt_rr, 0, unit_fp, 1);
		add_op(e_fa, e_fa, fmt_rr, 0, unit_fp, 1);
		add_op(e_fm, e_fm, fmt_rr, 0, unit_fp, 1);
		add_op(e_shl, e_shl, fmt_rr, 0, unit_fx2, 1);
		add_op(e_cntb, e_cntb, fmt_rr, 0, unit_byte, 1);
		add_op(e_a, e_a, fmt_rr, 0, unit_fx1, 1);
		add_op(e_and, e_and, fmt_rr, 0, unit_fx1, 1);
		add_op(e_nop, e_nop, fmt_rr, 0, unit_fp, 0);
		add_op(e_shli, e_shli, fmt_ri7, 0, unit_fx2, 1);
		add_op(e_roti, e_roti, fmt_ri7, 0, unit_fx2, 1);
		add_op(o_lqd, o_lqd, fmt_ri10, 1, unit_ls, 1);
		add_op(o_lqa, o_lqa, fmt_ri16, 1, unit_ls, 1);
		add_op(o_stqa, o_stqa, fmt_ri16, 1, unit_ls, 0);
		add_op(o_br, o_br, fmt_ri16, 1, unit_br, 0);
		add_op(o_brsl, o_brsl, fmt_ri16, 1, unit_br, 1);
		add_op(o_brz, o_brz, fmt_ri16, 1, unit_br, 0);
		add_op(o_shlqbi, o_shlqbi, fmt_rr, 1, unit_perm, 1);
		add_op(o_lqx, o_lqx, fmt_rr, 1, unit_ls, 1);
		add_op(o_stqx, o_stqx, fmt_rr, 1, unit_ls, 0);
		add_op(o_bi, o_bi, fmt_rr, 1, unit_br, 0);
		add_op(o_lnop, o_lnop, fmt_rr, 1, unit_perm, 0);
		add_op(o_shlqbii, o_shlqbii, fmt_ri7, 1, unit_perm, 1);
		add_op(o_rotqbyi, o_rotqbyi, fmt_ri7, 1, unit_perm, 1);
		add_op(11'b00000000010, o_illegal, fmt_rr, 1, unit_perm, 0);	// unknown to both
	endtask

	function automatic int prefix_len(input format_e f);
		case (f)
			fmt_rrr:  return 4;
			fmt_ri18: return 7;
			fmt_ri10: return 8;
			fmt_ri16: return 9;
			fmt_ri8:  return 10;
			default:  return 11;
		endcase
	endfunction

	function automatic logic [0:31] build_word(input int e);
		logic [0:31] w;
		w = $random(seed);
		for (int b = 0; b < prefix_len(t_fmt[e]); b++)
			w[b] = t_opc[e][b];	// random fields behind the opcode
		return w;
	endfunction

	function automatic int pick_op();
		return {$random(seed)} % n_tab;
	endfunction

	// expected bundle from the field rules
	function automatic bundle_t make_bundle(input logic [0:31] w, input int e);
		bundle_t b;
		b = '0;
		b.valid = 1'b1;
		b.op = t_op[e];
		b.fmt = t_fmt[e];
		b.unit = t_unit[e];
		b.rw = t_rw[e];
		b.ra = w[18:24];
		b.rb = w[11:17];
		b.rt = (t_fmt[e] == fmt_rrr) ? w[4:10] : w[25:31];
		b.rc = t_odd[e] ? 7'd0 : w[25:31];
		case (t_fmt[e])
			fmt_ri7:  b.imm = 18'($signed(w[11:17]));
			fmt_ri8:  b.imm = 18'($signed(w[10:17]));
			fmt_ri10: b.imm = 18'($signed(w[8:17]));
			fmt_ri16: b.imm = 18'($signed(w[9:24]));
			fmt_ri18: b.imm = w[7:24];
			default:  b.imm = '0;
		endcase
		return b;
	endfunction

	function automatic issue_t alone(input bundle_t b, input logic odd);
		issue_t x;
		x = '0;
		if (odd)
			x.od = b;
		else
			x.ev = b;
		return x;
	endfunction

	// pushes expected issues and returns the split flag (e < 0 is stop)
	function automatic logic predict(input logic [0:31] w0, input int e0,
			input logic [0:31] w1, input int e1);
		bundle_t b0, b1;
		issue_t x;
		logic split;
		if (e0 < 0)
			return 1'b0;
		b0 = make_bundle(w0, e0);
		if (e1 < 0) begin
			exp_q.push_back(alone(b0, t_odd[e0]));
			return 1'b0;
		end
		b1 = make_bundle(w1, e1);
		split = (t_odd[e0] == t_odd[e1]) || (b0.rw && b1.rw && b0.rt == b1.rt);
		if (split) begin
			exp_q.push_back(alone(b0, t_odd[e0]));
			exp_q.push_back(alone(b1, t_odd[e1]));
		end else begin
			x.ev = t_odd[e0] ? b1 : b0;
			x.od = t_odd[e0] ? b0 : b1;
			x.first_odd = t_odd[e0];
			exp_q.push_back(x);
		end
		return split;
	endfunction

	task automatic run_pair(input int e0, input int e1, input logic force_rt);
		logic [0:31] w0, w1;
		logic split;
		int n;
		w0 = build_word(e0);
		w1 = build_word(e1);
		if (force_rt) begin	// same target in both slots
			if (t_fmt[e1] == fmt_rrr)
				w1[4:10] = (t_fmt[e0] == fmt_rrr) ? w0[4:10] : w0[25:31];
			else
				w1[25:31] = (t_fmt[e0] == fmt_rrr) ? w0[4:10] : w0[25:31];
		end
		instr0 = w0;	// just past a rising edge here
		instr1 = w1;
		pc = pc + 8'd1;
		split = predict(w0, e0, w1, e1);
		@(negedge clk);
		check_value("stall", stall, split);
		n = 0;
		while (stall) begin	// fetch holds the pair
			@(negedge clk);
			n++;
			if (n > 4)
				report_failure("stall stayed high on a split pair");
		end
		check_value("stall_cycles", n, split);
		@(posedge clk);	// pair consumed at this edge
		#1;
	endtask

	task automatic drain_queue();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			n++;
			if (n > 10)
				report_failure("expected issue never appeared");
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1 reset = 1'b1;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
	endtask

	task automatic stop_run(input logic in_slot0);
		int e;
		logic [0:31] w;
		e = pick_op();
		w = build_word(e);
		instr0 = in_slot0 ? 32'd0 : w;
		instr1 = in_slot0 ? w : 32'd0;
		if (in_slot0)
			void'(predict(32'd0, -1, w, e));
		else
			void'(predict(w, e, 32'd0, -1));
		@(negedge clk);
		check_value("stall", stall, 0);
		repeat (6) begin	// stays parked until reset
			@(negedge clk);
			check_value("finished", finished, 1);
			check_value("stall", stall, 1);
		end
		drain_queue();
		apply_reset();
	endtask

	task automatic check_issue(input issue_t x);
		check_value("even_valid", even_valid, x.ev.valid);
		check_value("odd_valid", odd_valid, x.od.valid);
		check_value("first_odd", first_odd, x.first_odd);
		check_value("even_op", even_op, x.ev.op);
		check_value("even_format", even_format, x.ev.fmt);
		check_value("even_unit", even_unit, x.ev.unit);
		check_value("even_rt", even_rt, x.ev.rt);
		check_value("even_ra", even_ra, x.ev.ra);
		check_value("even_rb", even_rb, x.ev.rb);
		check_value("even_rc", even_rc, x.ev.rc);
		check_value("even_imm", even_imm, x.ev.imm);
		check_value("even_reg_write", even_reg_write, x.ev.rw);
		check_value("odd_op", odd_op, x.od.op);
		check_value("odd_format", odd_format, x.od.fmt);
		check_value("odd_unit", odd_unit, x.od.unit);
		check_value("odd_rt", odd_rt, x.od.rt);
		check_value("odd_ra", odd_ra, x.od.ra);
		check_value("odd_rb", odd_rb, x.od.rb);
		check_value("odd_imm", odd_imm, x.od.imm);
		check_value("odd_reg_write", odd_reg_write, x.od.rw);
	endtask

	// compare outputs mid-cycle against the expected issue order
	always @(negedge clk) begin
		if (!reset && (even_valid || odd_valid)) begin
			if (exp_q.size() == 0)
				report_failure("DUT issued with no issue expected");
			else
				check_issue(exp_q.pop_front());
		end
	end

	initial begin
		seed = 32'h64f0;
		reset = 1'b1;
		instr0 = '0;
		instr1 = '0;
		pc = '0;
		fill_table();
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		for (int i = 0; i < n_tab; i++) begin	// every opcode in both slots
			run_pair(i, pick_op(), 1'b0);
			run_pair(pick_op(), i, 1'b0);
		end
		repeat (400)
			run_pair(pick_op(), pick_op(), ({$random(seed)} % 4) == 0);
		stop_run(1'b0);
		repeat (20)
			run_pair(pick_op(), pick_op(), 1'b1);
		stop_run(1'b1);
		drain_queue();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== decode_stage.f ====
verilog/spu_isa_pkg.sv
verilog/decode_pkg.sv
verilog/even_decoder.sv
verilog/odd_decoder.sv
verilog/pair_dispatcher.sv
verilog/decode_stage.sv
tests/decode_stage_chk.sv
tests/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - verilog/spu_isa_pkg.sv
  - verilog/decode_pkg.sv
  - verilog/even_decoder.sv
  - verilog/odd_decoder.sv
  - verilog/pair_dispatcher.sv
  - verilog/decode_stage.sv
  - target: test
    files:
      - tests/decode_stage_chk.sv
      - tests/tb_decode_stage.sv
